// File: Makefile
TOP := decode_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

// File: design/decode_field_gen.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_field_gen import decode_pkg::*; (
  input  logic [`DEC_INSTR_W-1:0] instr,
  output dec_ctrl_t               ctrl
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [`DEC_IMM_W-1:0] imm_u;
  logic [`DEC_IMM_W-1:0] imm_j;
  logic [`DEC_IMM_W-1:0] imm_i;
  logic [`DEC_IMM_W-1:0] imm_s;
  logic [`DEC_IMM_W-1:0] imm_b;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];

  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    ctrl             = '0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.alu_fn      = ALU_OR;     // LUI passes imm through
    ctrl.sel_a       = SEL_IMM;
    ctrl.sel_b       = SEL_IMM;
    ctrl.cmp_fn      = funct3;
    ctrl.ls_size     = instr[13:12];
    ctrl.load_signed = !instr[14];
    ctrl.is_alu      = 1'b1;

    case (opcode)
      OP_LUI: begin
        ctrl.uses_rd = 1'b1;
        ctrl.imm     = imm_u;
      end
      OP_AUIPC: begin
        ctrl.uses_rd = 1'b1;
        ctrl.alu_fn  = ALU_ADD_SUB;
        ctrl.sel_a   = SEL_PC;
        ctrl.imm     = imm_u;
      end
      OP_JAL: begin
        ctrl.uses_rd = 1'b1;
        ctrl.alu_fn  = ALU_ADD_SUB;
        ctrl.sel_a   = SEL_PC;
        ctrl.imm     = imm_j;
        ctrl.branch  = 1'b1;
        ctrl.jump    = 1'b1;
      end
      OP_JALR: begin
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rd  = 1'b1;
        ctrl.alu_fn   = ALU_ADD_SUB;
        ctrl.sel_a    = SEL_REG;
        ctrl.imm      = imm_i;
        ctrl.branch   = 1'b1;
        ctrl.jump     = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
        ctrl.alu_fn   = ALU_ADD_SUB;  // Target address
        ctrl.sel_a    = SEL_PC;
        ctrl.imm      = imm_b;
        ctrl.branch   = 1'b1;
      end
      OP_LOAD, OP_STORE: begin
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = (opcode == OP_STORE);
        ctrl.uses_rd  = (opcode == OP_LOAD);
        ctrl.alu_fn   = ALU_ADD_SUB;
        ctrl.sel_a    = SEL_REG;
        ctrl.imm      = (opcode == OP_STORE) ? imm_s : imm_i;
        ctrl.is_alu   = 1'b0;         // Address goes to the AGU
        ctrl.load     = (opcode == OP_LOAD);
        ctrl.store    = (opcode == OP_STORE);
      end
      OP_IMM, OP_IMM_32: begin
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rd  = 1'b1;
        ctrl.alu_fn   = alu_fn_e'(funct3);
        ctrl.alu_mod  = (funct3 == 3'b101) && instr[30];  // SRAI only
        ctrl.sel_a    = SEL_REG;
        ctrl.imm      = imm_i;
        ctrl.half     = (opcode == OP_IMM_32);
      end
      OP_OP, OP_32: begin
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
        ctrl.uses_rd  = 1'b1;
        ctrl.alu_fn   = alu_fn_e'(funct3);
        ctrl.alu_mod  = instr[30];
        ctrl.sel_a    = SEL_REG;
        ctrl.sel_b    = SEL_REG;
        ctrl.half     = (opcode == OP_32);
      end
      OP_FENCE: begin
        ctrl.is_alu   = 1'b0;
        ctrl.is_fence = 1'b1;
      end
      OP_SYSTEM: ctrl.is_alu = 1'b0;  // ECALL, EBREAK trap
      default:   ctrl.is_alu = 1'b0;
    endcase

    if (ctrl.uses_rd) begin
      ctrl.rd = instr[11:7];
    end
  end

endmodule

// File: design/decode_legality_check.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_legality_check import decode_pkg::*; (
  input  logic [`DEC_INSTR_W-1:0] instr,
  input  logic                    up_exception,
  input  logic [`DEC_CAUSE_W-1:0] up_ecause,
  output dec_fault_t              fault
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       detect;
  ecause_e    cause;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    detect = 1'b0;
    cause  = EC_ILLEGAL_INSTRUCTION;

    case (opcode)
      OP_LUI, OP_AUIPC, OP_JAL: detect = 1'b0;
      OP_JALR:   detect = (funct3 != 3'b000);
      OP_BRANCH: detect = (funct3[2:1] == 2'b01);
      OP_LOAD:   detect = (funct3 == 3'b111);   // No LDU in RV64
      OP_STORE:  detect = funct3[2];
      OP_IMM: begin
        // 6-bit shamt
        detect = (funct3 == 3'b001 && instr[31:26] != 6'b0) ||
                 (funct3 == 3'b101 && (instr[31] || instr[29:26] != 4'b0));
      end
      OP_IMM_32: begin
        detect = (funct3 == 3'b001 && instr[31:25] != 7'b0) ||
                 (funct3 == 3'b101 && (instr[31] || instr[29:25] != 5'b0));
      end
      OP_OP, OP_32: begin
        detect = (funct7 != 7'b0) &&
                 (funct7 != 7'b0100000 || (funct3 != 3'b000 && funct3 != 3'b101));
      end
      OP_FENCE: detect = (funct3[2:1] != 2'b00);
      OP_SYSTEM: begin
        detect = 1'b1;                          // Always traps
        if (funct3 == 3'b000 && instr[24:21] == 4'b0) begin
          cause = instr[20] ? EC_BREAKPOINT : EC_ENV_CALL_M;
          if (funct7 != 7'b0 || instr[19:15] != 5'b0 || instr[11:7] != 5'b0) begin
            cause = EC_ILLEGAL_INSTRUCTION;
          end
        end
      end
      default: detect = 1'b1;
    endcase

    // Decoder cause wins over upstream
    if (detect) begin
      fault.exception = 1'b1;
      fault.ecause    = cause;
    end else begin
      fault.exception = up_exception;
      fault.ecause    = up_ecause;
    end
  end

endmodule

// File: design/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

  typedef enum logic [6:0] {
    OP_LOAD    = 7'b0000011,
    OP_FENCE   = 7'b0001111,
    OP_IMM     = 7'b0010011,
    OP_AUIPC   = 7'b0010111,
    OP_IMM_32  = 7'b0011011,
    OP_STORE   = 7'b0100011,
    OP_OP      = 7'b0110011,
    OP_LUI     = 7'b0110111,
    OP_32      = 7'b0111011,
    OP_BRANCH  = 7'b1100011,
    OP_JALR    = 7'b1100111,
    OP_JAL     = 7'b1101111,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  // Same order as funct3
  typedef enum logic [2:0] {
    ALU_ADD_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL_SRA, ALU_OR, ALU_AND_CLR
  } alu_fn_e;

  typedef enum logic [1:0] {
    SEL_IMM = 2'd0,
    SEL_REG = 2'd1,
    SEL_PC  = 2'd2
  } alu_sel_e;

  typedef enum logic [3:0] {
    EC_ILLEGAL_INSTRUCTION = 4'd2,
    EC_BREAKPOINT          = 4'd3,
    EC_ENV_CALL_M          = 4'd11
  } ecause_e;

  typedef struct packed {
    logic [`DEC_ADDR_W-1:0]  pc;
    logic [`DEC_ADDR_W-1:0]  next_pc;
    logic [`DEC_INSTR_W-1:0] instr;
    logic                    exception;
    logic [`DEC_CAUSE_W-1:0] ecause;   // Raised upstream
  } fetch_bundle_t;

  typedef struct packed {
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  uses_rd;
    logic [`DEC_REG_W-1:0] rs1;
    logic [`DEC_REG_W-1:0] rs2;
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_IMM_W-1:0] imm;
    alu_fn_e               alu_fn;
    logic                  alu_mod;    // SUB, SRA
    alu_sel_e              sel_a;
    alu_sel_e              sel_b;
    logic [2:0]            cmp_fn;
    logic [1:0]            ls_size;
    logic                  load_signed;
    logic                  jump;
    logic                  branch;
    logic                  is_alu;
    logic                  load;
    logic                  store;
    logic                  half;       // 32-bit word op
    logic                  is_fence;
  } dec_ctrl_t;

  typedef struct packed {
    logic                    exception;
    logic [`DEC_CAUSE_W-1:0] ecause;
  } dec_fault_t;

  typedef struct packed {
    logic [`DEC_ADDR_W-1:0] pc;
    logic [`DEC_ADDR_W-1:0] next_pc;
    dec_ctrl_t              ctrl;
    dec_fault_t             fault;
  } dec_uop_t;

endpackage

// File: design/decode_stage_reg.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_stage_reg import decode_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [`DEC_ADDR_W-1:0] pc,
  input  logic [`DEC_ADDR_W-1:0] next_pc,
  input  dec_ctrl_t              ctrl,
  input  dec_fault_t             fault,
  input  logic                   valid_in,
  input  logic                   ready_in,
  input  logic                   branch_back,
  input  logic                   trapped,
  output logic                   ready_out,
  output logic                   valid_out,
  output dec_uop_t               uop
);

  logic accept;
  logic consume;

  assign accept  = valid_in && ready_out;
  assign consume = valid_out && ready_in;

  always_ff @(posedge clk) begin
    if (rstn) begin
      ready_out <= 1'b1;
      valid_out <= 1'b0;
    end else begin
      if (branch_back || trapped) begin
        ready_out <= 1'b1;                   // Redirect done
      end else if (consume) begin
        ready_out <= !uop.ctrl.branch;       // Hold until branch resolves
      end else if (accept) begin
        ready_out <= 1'b0;
      end

      if (accept) begin
        valid_out <= !trapped;               // Squash while trapped
      end else if (consume) begin
        valid_out <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      uop <= '0;
    end else if (accept) begin
      uop.pc      <= pc;
      uop.next_pc <= next_pc;
      uop.ctrl    <= ctrl;
      uop.fault   <= fault;
    end
  end

  ap_hold_uop: assert property (
    @(posedge clk) disable iff (rstn)
    valid_out && !ready_in |=> valid_out && $stable(uop))
    else $error("uop changed under back-pressure");

  ap_valid_src: assert property (
    @(posedge clk) disable iff (rstn)
    $rose(valid_out) |-> $past(accept))
    else $error("valid_out rose without an accept");

endmodule

// File: design/decode_top.sv
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
  input  logic          clk,
  input  logic          rstn,
  input  fetch_bundle_t fetch,
  input  logic          valid_in,
  input  logic          ready_in,
  input  logic          branch_back,
  input  logic          trapped,
  output logic          ready_out,
  output logic          valid_out,
  output dec_uop_t      uop
);

  dec_ctrl_t  ctrl;
  dec_fault_t fault;

  decode_field_gen i_field_gen (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  decode_legality_check i_legality_check (
    .instr        (fetch.instr),
    .up_exception (fetch.exception),
    .up_ecause    (fetch.ecause),
    .fault        (fault)
  );

  decode_stage_reg i_stage_reg (
    .clk         (clk),
    .rstn        (rstn),
    .pc          (fetch.pc),
    .next_pc     (fetch.next_pc),
    .ctrl        (ctrl),
    .fault       (fault),
    .valid_in    (valid_in),
    .ready_in    (ready_in),
    .branch_back (branch_back),
    .trapped     (trapped),
    .ready_out   (ready_out),
    .valid_out   (valid_out),
    .uop         (uop)
  );

endmodule

// File: include/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Fetched instruction word
`define DEC_INSTR_W 32
// pc and next_pc
`define DEC_ADDR_W 32
// Architectural register index
`define DEC_REG_W 5
`define DEC_CAUSE_W 4
// Sign-extended immediate
`define DEC_IMM_W 32

`endif

// File: project.f
+incdir+include
design/decode_pkg.sv
design/decode_field_gen.sv
design/decode_legality_check.sv
design/decode_stage_reg.sv
design/decode_top.sv
verif/decode_tb.sv

// File: verif/decode_tb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_tb import decode_pkg::*; ();

  localparam int TIMEOUT = 50;
  localparam int NCOL    = 23;

  logic          clk;
  logic          rstn;
  fetch_bundle_t fetch;
  logic          valid_in;
  logic          ready_in;
  logic          branch_back;
  logic          trapped;
  logic          ready_out;
  logic          valid_out;
  dec_uop_t      uop;

  integer        seed;
  int            errors;
  int            tests;
  int            failed_tests;
  logic          timed_out;
  logic [31:0]   col [NCOL];      // One parsed data line
  logic [31:0]   act [16];
  string         names [16];

  decode_top i_dut (
    .clk         (clk),
    .rstn        (rstn),
    .fetch       (fetch),
    .valid_in    (valid_in),
    .ready_in    (ready_in),
    .branch_back (branch_back),
    .trapped     (trapped),
    .ready_out   (ready_out),
    .valid_out   (valid_out),
    .uop         (uop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at time %0t while waiting for %s", $time, what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - err_start);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready_out !== 1'b1 && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("ready_out");
    end
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (valid_out !== 1'b1 && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("valid_out");
    end
  endtask

  task automatic check_fields();
    check_value("uop.pc", uop.pc, col[0]);
    check_value("uop.next_pc", uop.next_pc, col[0] + 32'd4);
    check_value("exception", 32'(uop.fault.exception), col[5]);
    check_value("ecause", 32'(uop.fault.ecause), col[6]);
    // Decoder-raised faults only check the cause
    if (!col[5][0] || col[2][0]) begin
      act[0]  = uop.ctrl.imm;
      act[1]  = 32'(uop.ctrl.rd);
      act[2]  = 32'(uop.ctrl.uses_rs1);
      act[3]  = 32'(uop.ctrl.uses_rs2);
      act[4]  = 32'(uop.ctrl.uses_rd);
      act[5]  = 32'(uop.ctrl.alu_fn);
      act[6]  = 32'(uop.ctrl.alu_mod);
      act[7]  = 32'(uop.ctrl.sel_a);
      act[8]  = 32'(uop.ctrl.sel_b);
      act[9]  = 32'(uop.ctrl.branch);
      act[10] = 32'(uop.ctrl.jump);
      act[11] = 32'(uop.ctrl.load);
      act[12] = 32'(uop.ctrl.store);
      act[13] = 32'(uop.ctrl.is_alu);
      act[14] = 32'(uop.ctrl.half);
      act[15] = 32'(uop.ctrl.is_fence);
      for (int i = 0; i < 16; i++) begin
        check_value(names[i], act[i], col[7 + i]);
      end
      // Register and funct3 fields of the RV64I encoding
      if (col[9][0]) check_value("rs1", 32'(uop.ctrl.rs1), 32'(col[1][19:15]));
      if (col[10][0]) check_value("rs2", 32'(uop.ctrl.rs2), 32'(col[1][24:20]));
      if (col[16][0] && !col[17][0]) begin
        check_value("cmp_fn", 32'(uop.ctrl.cmp_fn), 32'(col[1][14:12]));
      end
      if (col[18][0] || col[19][0]) begin
        check_value("ls_size", 32'(uop.ctrl.ls_size), 32'(col[1][13:12]));
      end
      if (col[18][0]) begin
        check_value("load_signed", 32'(uop.ctrl.load_signed), 32'(!col[1][14]));
      end
    end
  endtask

  task automatic check_squash();
    for (int i = 0; i < 5; i++) begin
      check_value("valid_out", 32'(valid_out), 32'd0);
      @(negedge clk);
    end
    check_value("ready_out", 32'(ready_out), 32'd1);
  endtask

  task automatic run_vector();
    dec_uop_t snap;
    int       hold;
    int       err_start;
    logic     expect_hold;
    err_start   = errors;
    tests++;
    expect_hold = col[16][0] || col[17][0];
    wait_ready();
    if (timed_out) return;
    fetch.pc        = col[0];
    fetch.next_pc   = col[0] + 32'd4;
    fetch.instr     = col[1];
    fetch.exception = col[2][0];
    fetch.ecause    = col[3][`DEC_CAUSE_W-1:0];
    trapped         = col[4][0];
    valid_in        = 1'b1;
    ready_in        = 1'b0;
    @(negedge clk);
    valid_in = 1'b0;
    trapped  = 1'b0;
    if (col[4][0]) begin
      check_squash();
    end else begin
      wait_valid();
      if (timed_out) return;
      check_fields();
      snap = uop;
      hold = $unsigned($random(seed)) % 6;
      repeat (hold) begin
        @(negedge clk);
        check_value("valid_out", 32'(valid_out), 32'd1);
        check_value("ready_out", 32'(ready_out), 32'd0);
        check_value("uop changed", 32'(uop != snap), 32'd0);
      end
      ready_in = 1'b1;                        // Consume
      @(negedge clk);
      ready_in = 1'b0;
      check_value("valid_out", 32'(valid_out), 32'd0);
      if (expect_hold) begin
        repeat (3) begin
          check_value("ready_out", 32'(ready_out), 32'd0);
          @(negedge clk);
        end
        branch_back = 1'b1;
        @(negedge clk);
        branch_back = 1'b0;
      end
      check_value("ready_out", 32'(ready_out), 32'd1);
    end
    report_test($sformatf("instr %h", col[1]), err_start);
  endtask

  initial begin
    string line;
    int    fd;
    int    n;
    int    err_start;
    seed         = 82;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    rstn         = 1'b1;
    fetch        = '0;
    valid_in     = 1'b0;
    ready_in     = 1'b0;
    branch_back  = 1'b0;
    trapped      = 1'b0;
    names = '{"imm", "rd", "uses_rs1", "uses_rs2", "uses_rd", "alu_fn", "alu_mod",
              "sel_a", "sel_b", "branch", "jump", "load", "store", "is_alu", "half",
              "is_fence"};
    repeat (16) @(negedge clk);
    rstn = 1'b0;
    @(negedge clk);

    err_start = errors;
    tests++;
    check_value("valid_out", 32'(valid_out), 32'd0);
    check_value("ready_out", 32'(ready_out), 32'd1);
    check_value("uop any bit", 32'(|uop), 32'd0);
    report_test("reset", err_start);

    fd = $fopen("verif/decode_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file verif/decode_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line,
                      "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                      col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                      col[15], col[16], col[17], col[18], col[19], col[20], col[21],
                      col[22]);
          if (n != NCOL) begin
            $display("Data line has %0d columns instead of %0d: %s", n, NCOL, line);
            errors++;
          end else begin
            run_vector();
          end
        end
      end
      $fclose(fd);
    end
    finish_run();
  end

endmodule

// File: verif/decode_testdata.txt
# pc instr up_exc up_cause trapped | exc cause imm rd uses_rs1 uses_rs2 uses_rd
# alu_fn alu_mod sel_a sel_b branch jump load store is_alu half is_fence (all hex)
00001000 123452b7 0 0 0 0 0 12345000 05 0 0 1 6 0 0 0 0 0 0 0 1 0 0
00001004 fffff517 0 0 0 0 0 fffff000 0a 0 0 1 0 0 2 0 0 0 0 0 1 0 0
00001008 fff10093 0 0 0 0 0 ffffffff 01 1 0 1 0 0 1 0 0 0 0 0 1 0 0
0000100c 43f25193 0 0 0 0 0 0000043f 03 1 0 1 5 1 1 0 0 0 0 0 1 0 0
00001010 7ff3029b 0 0 0 0 0 000007ff 05 1 0 1 0 0 1 0 0 0 0 0 1 1 0
00001014 409403b3 0 0 0 0 0 00000000 07 1 1 1 0 1 1 1 0 0 0 0 1 0 0
0000101c 40c5d53b 0 0 0 0 0 00000000 0a 1 1 1 5 1 1 1 0 0 0 0 1 1 0
00001020 ff813203 0 0 0 0 0 fffffff8 04 1 0 1 0 0 1 0 0 0 1 0 0 0 0
00001024 00532623 0 0 0 0 0 0000000c 00 1 1 0 0 0 1 0 0 0 0 1 0 0 0
00001028 00208863 0 0 0 0 0 00000010 00 1 1 0 0 0 2 0 1 0 0 0 1 0 0
0000102c 001000ef 0 0 0 0 0 00000800 01 0 0 1 0 0 2 0 1 1 0 0 1 0 0
00001030 00008067 0 0 0 0 0 00000000 00 1 0 1 0 0 1 0 1 1 0 0 1 0 0
00001034 0ff0000f 0 0 0 0 0 00000000 00 0 0 0 6 0 0 0 0 0 0 0 0 0 1
00001038 003100b3 1 1 0 1 1 00000000 01 1 1 1 0 0 1 1 0 0 0 0 1 0 0
0000103c 00100093 0 0 1 0 0 00000001 01 1 0 1 0 0 1 0 0 0 0 0 1 0 0
00001040 00000073 0 0 0 1 b 00000000 00 0 0 0 6 0 0 0 0 0 0 0 0 0 0
00001044 00100073 0 0 0 1 3 00000000 00 0 0 0 6 0 0 0 0 0 0 0 0 0 0
0000104c 30529073 0 0 0 1 2 00000000 00 0 0 0 6 0 0 0 0 0 0 0 0 0 0
00001050 00009067 0 0 0 1 2 00000000 00 1 0 1 0 0 1 0 1 1 0 0 1 0 0
00001054 00a00513 0 0 0 0 0 0000000a 0a 1 0 1 0 0 1 0 0 0 0 0 1 0 0
00001058 00007003 0 0 0 1 2 00000000 00 1 0 1 0 0 1 0 0 0 1 0 0 0 0
0000105c 0020a063 0 0 0 1 2 00000000 00 1 1 0 0 0 2 0 1 0 0 0 1 0 0
00001060 0200909b 0 0 0 1 2 00000020 01 1 0 1 1 0 1 0 0 0 0 0 1 1 0
00001064 403140b3 0 0 0 1 2 00000000 01 1 1 1 4 1 1 1 0 0 0 0 1 0 0
00001068 0000007f 0 0 0 1 2 00000000 00 0 0 0 6 0 0 0 0 0 0 0 0 0 0
